// ==== Bender.yml ====
package:
  name: icache

export_include_dirs:
  - common

sources:
  - files:
      - common/icache_pkg.sv
      - common/mem_bus_pkg.sv
      - src/cache_array.sv
      - lookup/inst_align.sv
      - lookup/fetch_ctrl.sv
      - refill/mem_reader.sv
      - src/icache_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/icache_tb.sv

// ==== all.f ====
+incdir+common
+incdir+tb
common/icache_pkg.sv
common/mem_bus_pkg.sv
src/cache_array.sv
lookup/inst_align.sv
lookup/fetch_ctrl.sv
refill/mem_reader.sv
src/icache_top.sv
tb/icache_tb.sv

// ==== common/icache_macros.svh ====
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// 32-bit fetch address split
// tag | index | offset
`define ICACHE_TAG_W 19
`define ICACHE_IDX_W 7
`define ICACHE_OFS_W 6

// data rows are 128 bits, four per 64-byte line
`define ICACHE_ROW_W 128

// refill burst, beats minus one
// 16 words of 32 bits fill one line
`define ICACHE_BURST_LEN 15

// bit 31 set means the uncached region
`define ICACHE_UNCACHED_BIT 31

`endif

// ==== common/icache_pkg.sv ====
`include "icache_macros.svh"

package icache_pkg;

  // row select bits inside the line offset
  localparam int ROW_SEL_W = `ICACHE_OFS_W - $clog2(`ICACHE_ROW_W / 8);

  // overlays a full 32-bit fetch address
  typedef struct packed {
    logic [`ICACHE_TAG_W-1:0] tag;
    logic [`ICACHE_IDX_W-1:0] index;
    logic [`ICACHE_OFS_W-1:0] offset;
  } fetch_addr_t;

  // one tag array entry per line
  typedef struct packed {
    logic                     valid;
    logic [`ICACHE_TAG_W-1:0] tag;
  } tag_entry_t;

  // word[0] holds the lowest address
  typedef struct packed {
    logic [`ICACHE_ROW_W/32-1:0][31:0] word;
  } data_row_t;

  // data array address, line index then row in line
  typedef struct packed {
    logic [`ICACHE_IDX_W-1:0] index;
    logic [ROW_SEL_W-1:0]     row_sel;
  } row_addr_t;

endpackage

// ==== common/mem_bus_pkg.sv ====
`include "icache_macros.svh"

package mem_bus_pkg;

  // read request, held with valid until its last beat
  typedef struct packed {
    // byte address, word aligned
    logic [`ICACHE_TAG_W+`ICACHE_IDX_W+`ICACHE_OFS_W-1:0] addr;
    // beats minus one
    logic [7:0]                                           len;
  } mem_req_t;

  // one beat per cycle with valid and beat_ready high
  typedef struct packed {
    logic [31:0] rdata;
    logic        beat_ready;
  } mem_rsp_t;

endpackage

// ==== lookup/fetch_ctrl.sv ====
`include "icache_macros.svh"

module fetch_ctrl
  import icache_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     fetch_valid_i,
  input  fetch_addr_t              fetch_addr_i,
  output logic [31:0]              fetch_rdata_o,
  output logic                     fetch_rdata_valid_o,
  output logic [`ICACHE_IDX_W-1:0] tag_rd_addr_o,
  input  tag_entry_t               tag_i,
  output row_addr_t                row_rd_addr_o,
  input  data_row_t                row_i,
  output logic                     start_o,
  output logic                     start_uncached_o,
  output fetch_addr_t              req_addr_o,
  input  logic                     done_i,
  input  logic [31:0]              uncached_word_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_WAIT
  } state_e;

  state_e      state_q;
  state_e      state_d;
  fetch_addr_t addr_q;
  fetch_addr_t rd_addr;
  logic        in_lookup;
  logic        in_wait;
  logic        is_uncached;
  logic        hit;
  logic        unc_done;
  logic        take;
  logic [3:0]  align_ofs;
  logic [31:0] aligned_inst;

  assign in_lookup = (state_q == ST_LOOKUP);
  assign in_wait   = (state_q == ST_WAIT);

  // region check on the captured address
  assign is_uncached = addr_q[`ICACHE_UNCACHED_BIT];

  // tag compare against the entry read on the accept cycle
  assign hit = in_lookup && !is_uncached && tag_i.valid && (tag_i.tag == addr_q.tag);

  // uncached word arrives one cycle after its beat
  assign unc_done = in_wait && done_i && is_uncached;

  // new address accepted when idle or finishing a fetch
  assign take = fetch_valid_i && ((state_q == ST_IDLE) || hit || unc_done);

  // read with the new address, else hold the captured one
  // holding it lets the relook after a refill see the new line
  assign rd_addr       = take ? fetch_addr_i : addr_q;
  assign tag_rd_addr_o = rd_addr.index;
  assign row_rd_addr_o = '{
    index:   rd_addr.index,
    row_sel: rd_addr.offset[`ICACHE_OFS_W-1 -: ROW_SEL_W]
  };

  always_ff @(posedge clk) begin
    if (take) begin
      addr_q <= fetch_addr_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (fetch_valid_i) begin
          state_d = ST_LOOKUP;
        end
      end
      ST_LOOKUP: begin
        // miss and uncached both go to memory
        if (!hit) begin
          state_d = ST_WAIT;
        end else if (!fetch_valid_i) begin
          state_d = ST_IDLE;
        end
      end
      ST_WAIT: begin
        // refilled line is looked up once more
        if (done_i) begin
          state_d = (!is_uncached || fetch_valid_i) ? ST_LOOKUP : ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  // memory read kicked off from the lookup cycle
  assign start_o          = in_lookup && !hit;
  assign start_uncached_o = in_lookup && is_uncached;
  assign req_addr_o       = addr_q;

  // offset parked at zero unless a hit reads the row
  assign align_ofs = hit ? addr_q.offset[3:0] : 4'd0;

  inst_align inst_align_i (
    .row_i    (row_i),
    .offset_i (align_ofs),
    .inst_o   (aligned_inst)
  );

  // uncached words come back raw
  assign fetch_rdata_o       = is_uncached ? uncached_word_i : aligned_inst;
  assign fetch_rdata_valid_o = hit || unc_done;

  done_only_while_waiting: assert property (
    @(posedge clk) disable iff (rst)
    done_i |-> in_wait
  );

endmodule

// ==== lookup/inst_align.sv ====
module inst_align
  import icache_pkg::*;
(
  input  data_row_t   row_i,
  // byte offset within the row, bit 0 unused
  input  logic [3:0]  offset_i,
  output logic [31:0] inst_o
);

  logic [7:0][15:0] half;
  logic [2:0]       hsel;
  logic [15:0]      lo_half;
  logic [15:0]      hi_half;
  logic             is_rvc;

  // row viewed as eight halfwords
  assign half = row_i;
  assign hsel = offset_i[3:1];

  assign lo_half = half[hsel];
  // wraps to halfword 0 at the row end, cross-row fetch not supported
  assign hi_half = half[hsel + 3'd1];

  // RVC when the low opcode bits are not both one
  assign is_rvc = (lo_half[1:0] != 2'b11);

  // compressed zero-extended, else both halfwords
  assign inst_o = is_rvc ? {16'h0000, lo_half} : {hi_half, lo_half};

  // a 32-bit instruction here would need the next row
  no_cross_row_inst: assert final (
    !((offset_i[3:1] === 3'd7) && (lo_half[1:0] === 2'b11))
  );

endmodule

// ==== refill/mem_reader.sv ====
`include "icache_macros.svh"

module mem_reader
  import icache_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start_i,
  input  logic                     uncached_i,
  input  fetch_addr_t              addr_i,
  output logic                     mem_req_valid_o,
  output mem_req_t                 mem_req_o,
  input  mem_rsp_t                 mem_rsp_i,
  output logic                     row_wr_en_o,
  output row_addr_t                row_wr_addr_o,
  output data_row_t                row_wr_data_o,
  output logic                     tag_wr_en_o,
  output logic [`ICACHE_IDX_W-1:0] tag_wr_addr_o,
  output tag_entry_t               tag_wr_data_o,
  output logic                     done_o,
  output logic [31:0]              uncached_word_o
);

  localparam int CNT_W = $clog2(`ICACHE_BURST_LEN + 1);

  logic             req_valid_q;
  mem_req_t         req_q;
  logic [CNT_W-1:0] beat_cnt_q;
  logic             uncached_q;
  logic             done_q;
  logic [2:0][31:0] row_buf_q;
  logic [31:0]      word_q;
  fetch_addr_t      line_addr;
  logic             beat;
  logic             last_beat;
  logic             row_end;

  assign beat      = req_valid_q && mem_rsp_i.beat_ready;
  assign last_beat = beat && (8'(beat_cnt_q) == req_q.len);
  // fourth word of a row
  assign row_end   = (beat_cnt_q[1:0] == 2'd3);

  // request address seen as tag, index, offset
  assign line_addr = req_q.addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_valid_q <= 1'b0;
      beat_cnt_q  <= '0;
      uncached_q  <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      // one cycle after the last beat
      done_q <= last_beat;
      if (start_i) begin
        req_valid_q <= 1'b1;
        beat_cnt_q  <= '0;
        uncached_q  <= uncached_i;
      end else if (last_beat) begin
        req_valid_q <= 1'b0;
      end else if (beat) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      if (uncached_i) begin
        // single word
        req_q.addr <= {addr_i[31:2], 2'b00};
        req_q.len  <= 8'd0;
      end else begin
        // whole line from offset 0
        req_q.addr <= {addr_i.tag, addr_i.index, `ICACHE_OFS_W'(0)};
        req_q.len  <= 8'(`ICACHE_BURST_LEN);
      end
    end
    // first three words of a row wait here
    if (beat && !uncached_q && !row_end) begin
      row_buf_q[beat_cnt_q[1:0]] <= mem_rsp_i.rdata;
    end
    if (beat && uncached_q) begin
      word_q <= mem_rsp_i.rdata;
    end
  end

  assign mem_req_valid_o = req_valid_q;
  assign mem_req_o       = req_q;

  // row written with the fourth beat straight from the bus
  assign row_wr_en_o   = beat && !uncached_q && row_end;
  assign row_wr_addr_o = '{index: line_addr.index, row_sel: beat_cnt_q[CNT_W-1:2]};
  assign row_wr_data_o = {mem_rsp_i.rdata, row_buf_q};

  // tag valid with the last row
  assign tag_wr_en_o   = last_beat && !uncached_q;
  assign tag_wr_addr_o = line_addr.index;
  assign tag_wr_data_o = '{valid: 1'b1, tag: line_addr.tag};

  assign done_o          = done_q;
  assign uncached_word_o = word_q;

  // bus holds the request through a stall
  req_stable_on_stall: assert property (
    @(posedge clk) disable iff (rst)
    (req_valid_q && !mem_rsp_i.beat_ready) |=> (req_valid_q && $stable(req_q))
  );

  start_only_when_free: assert property (
    @(posedge clk) disable iff (rst)
    start_i |-> !req_valid_q
  );

endmodule

// ==== src/cache_array.sv ====
module cache_array
  import icache_pkg::*;
#(
  parameter type entry_t = tag_entry_t,
  parameter int  DEPTH   = 128
) (
  input  logic                     clk,
  input  logic                     rst,
  // registered read, data one cycle after the address
  input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
  output entry_t                   rd_data_o,
  input  logic                     wr_en_i,
  input  logic [$clog2(DEPTH)-1:0] wr_addr_i,
  input  entry_t                   wr_data_i
);

  entry_t mem_q [DEPTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      // clears valid bits of the tag array
      for (int i = 0; i < DEPTH; i++) begin
        mem_q[i] <= '0;
      end
      rd_data_o <= '0;
    end else begin
      if (wr_en_i) begin
        mem_q[wr_addr_i] <= wr_data_i;
      end
      // read before write on the same entry
      rd_data_o <= mem_q[rd_addr_i];
    end
  end

  wr_addr_in_range: assert property (
    @(posedge clk) disable iff (rst)
    wr_en_i |-> (int'(wr_addr_i) < DEPTH)
  );

endmodule

// ==== src/icache_top.sv ====
`include "icache_macros.svh"

module icache_top
  import icache_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  // fetch side
  input  logic        fetch_valid_i,
  input  fetch_addr_t fetch_addr_i,
  output logic [31:0] fetch_rdata_o,
  output logic        fetch_rdata_valid_o,
  // memory side
  output logic        mem_req_valid_o,
  output mem_req_t    mem_req_o,
  input  mem_rsp_t    mem_rsp_i
);

  // array read side, driven by the lookup FSM
  logic [`ICACHE_IDX_W-1:0] tag_rd_addr;
  tag_entry_t               tag_rd_data;
  row_addr_t                row_rd_addr;
  data_row_t                row_rd_data;

  // array write side, driven by the refill engine
  logic                     tag_wr_en;
  logic [`ICACHE_IDX_W-1:0] tag_wr_addr;
  tag_entry_t               tag_wr_data;
  logic                     row_wr_en;
  row_addr_t                row_wr_addr;
  data_row_t                row_wr_data;

  // controller to reader handoff
  logic        start;
  logic        start_uncached;
  fetch_addr_t req_addr;
  logic        done;
  logic [31:0] uncached_word;

  fetch_ctrl fetch_ctrl_i (
    .clk                 (clk),
    .rst                 (rst),
    .fetch_valid_i       (fetch_valid_i),
    .fetch_addr_i        (fetch_addr_i),
    .fetch_rdata_o       (fetch_rdata_o),
    .fetch_rdata_valid_o (fetch_rdata_valid_o),
    .tag_rd_addr_o       (tag_rd_addr),
    .tag_i               (tag_rd_data),
    .row_rd_addr_o       (row_rd_addr),
    .row_i               (row_rd_data),
    .start_o             (start),
    .start_uncached_o    (start_uncached),
    .req_addr_o          (req_addr),
    .done_i              (done),
    .uncached_word_i     (uncached_word)
  );

  mem_reader mem_reader_i (
    .clk             (clk),
    .rst             (rst),
    .start_i         (start),
    .uncached_i      (start_uncached),
    .addr_i          (req_addr),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_o       (mem_req_o),
    .mem_rsp_i       (mem_rsp_i),
    .row_wr_en_o     (row_wr_en),
    .row_wr_addr_o   (row_wr_addr),
    .row_wr_data_o   (row_wr_data),
    .tag_wr_en_o     (tag_wr_en),
    .tag_wr_addr_o   (tag_wr_addr),
    .tag_wr_data_o   (tag_wr_data),
    .done_o          (done),
    .uncached_word_o (uncached_word)
  );

  // one tag per line
  cache_array #(
    .entry_t (tag_entry_t),
    .DEPTH   (128)
  ) tag_array_i (
    .clk       (clk),
    .rst       (rst),
    .rd_addr_i (tag_rd_addr),
    .rd_data_o (tag_rd_data),
    .wr_en_i   (tag_wr_en),
    .wr_addr_i (tag_wr_addr),
    .wr_data_i (tag_wr_data)
  );

  // four rows per line
  cache_array #(
    .entry_t (data_row_t),
    .DEPTH   (512)
  ) data_array_i (
    .clk       (clk),
    .rst       (rst),
    .rd_addr_i (row_rd_addr),
    .rd_data_o (row_rd_data),
    .wr_en_i   (row_wr_en),
    .wr_addr_i (row_wr_addr),
    .wr_data_i (row_wr_data)
  );

endmodule

// ==== tb/icache_tests.svh ====
// one fetch, accepted from idle, result checked against the model
task automatic run_fetch(input logic [31:0] addr);
  int waited;
  @(posedge clk);
  #DRIVE_DELAY;
  fetch_valid = 1'b1;
  fetch_addr  = addr;
  // idle controller takes it on this edge
  @(posedge clk);
  #DRIVE_DELAY;
  fetch_valid = 1'b0;
  waited = 0;
  @(negedge clk);
  while (!fetch_rdata_valid) begin
    waited++;
    if (waited > FETCH_CYCLES) begin
      end_with_fail($sformatf("no fetch response for address %h", addr));
    end
    @(negedge clk);
  end
  check("fetch_rdata_o", fetch_rdata, expected_inst(addr));
  // valid for a single cycle
  @(negedge clk);
  check("fetch_rdata_valid_o", fetch_rdata_valid, 1'b0);
endtask

task automatic reset_and_first_miss();
  int          reqs;
  int          beats;
  logic [31:0] addr;
  @(negedge clk);
  check("mem_req_valid_o", mem_req_valid, 1'b0);
  check("fetch_rdata_valid_o", fetch_rdata_valid, 1'b0);
  addr  = 32'h0000_0106;
  reqs  = req_count;
  beats = beat_count;
  run_fetch(addr);
  check("request count", req_count - reqs, 1);
  check("mem_req_o.addr", last_req.addr, {addr[31:6], 6'b0});
  check("mem_req_o.len", last_req.len, `ICACHE_BURST_LEN);
  check("beat count", beat_count - beats, `ICACHE_BURST_LEN + 1);
endtask

task automatic hit_same_line();
  int reqs;
  reqs = req_count;
  run_fetch(32'h0000_0128);
  run_fetch(32'h0000_013c);
  check("request count", req_count - reqs, 0);
endtask

task automatic halfword_alignment();
  logic [31:0] base;
  logic [31:0] word;
  int          reqs;
  base = 32'h0000_1000;
  // mix of both kinds, last halfword of each row compressed
  for (int w = 0; w < 16; w++) begin
    word        = $urandom();
    word[1:0]   = (w % 2 == 0) ? 2'b11 : 2'b01;
    word[17:16] = (w % 4 == 3) ? 2'b10 : 2'b11;
    mem[base[13:2] + w] = word;
  end
  reqs = req_count;
  for (int h = 0; h < 32; h++) begin
    run_fetch(base + 32'(2 * h));
  end
  check("request count", req_count - reqs, 1);
endtask

task automatic uncached_bypass();
  logic [31:0] addr;
  int          reqs;
  addr = 32'h8000_0206;
  reqs = req_count;
  run_fetch(addr);
  check("request count", req_count - reqs, 1);
  check("mem_req_o.addr", last_req.addr, {addr[31:2], 2'b00});
  check("mem_req_o.len", last_req.len, 0);
  // never cached, so memory is read again
  run_fetch(addr);
  check("request count", req_count - reqs, 2);
endtask

task automatic line_eviction();
  logic [31:0] seq [3];
  int          reqs;
  // same index, tags differ
  seq[0] = 32'h0000_2044;
  seq[1] = 32'h0000_4044;
  seq[2] = 32'h0000_2044;
  reqs = req_count;
  for (int i = 0; i < 3; i++) begin
    run_fetch(seq[i]);
    check("request count", req_count - reqs, i + 1);
  end
endtask

task automatic random_backpressure();
  logic [31:0] addr;
  gaps_on = 1'b1;
  for (int i = 0; i < 24; i++) begin
    addr = $urandom() & 32'h7fff_fffe;
    // keep clear of the last halfword of a row
    if (addr[3:1] == 3'd7) begin
      addr[1] = 1'b0;
    end
    if (i % 3 == 2) begin
      addr[`ICACHE_UNCACHED_BIT] = 1'b1;
    end
    run_fetch(addr);
  end
  gaps_on = 1'b0;
endtask

// ==== tb/icache_tb.sv ====
`include "icache_macros.svh"

module icache_tb
  import icache_pkg::*;
  import mem_bus_pkg::*;
();

  localparam int          CLK_PERIOD   = 40;
  localparam int          DRIVE_DELAY  = 2;
  localparam int          RESET_CYCLES = 16;
  localparam logic [31:0] SEED         = 32'hb42bf25d;
  // cycles from accept to data, refill with gaps included
  localparam int          FETCH_CYCLES = 200;
  localparam int          NUM_TESTS    = 6;
  localparam int          MAX_FETCHES  = 32;
  localparam int          WATCHDOG_TIME =
    (RESET_CYCLES + NUM_TESTS * MAX_FETCHES * FETCH_CYCLES) * CLK_PERIOD;
  // model aliases every 16 KB
  localparam int          MEM_WORDS    = 4096;

  logic        clk;
  logic        rst;
  logic        fetch_valid;
  fetch_addr_t fetch_addr;
  logic [31:0] fetch_rdata;
  logic        fetch_rdata_valid;
  logic        mem_req_valid;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;

  // memory model state
  logic [31:0] mem [MEM_WORDS];
  int          beat_idx;
  int          req_count;
  int          beat_count;
  logic        took;
  logic        req_seen;
  logic        gaps_on;
  mem_req_t    last_req;

  icache_top icache_top_i (
    .clk                 (clk),
    .rst                 (rst),
    .fetch_valid_i       (fetch_valid),
    .fetch_addr_i        (fetch_addr),
    .fetch_rdata_o       (fetch_rdata),
    .fetch_rdata_valid_o (fetch_rdata_valid),
    .mem_req_valid_o     (mem_req_valid),
    .mem_req_o           (mem_req),
    .mem_rsp_i           (mem_rsp)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic end_with_fail(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      end_with_fail($sformatf("Fail %s: got %h, expected %h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return mem[addr[13:2]];
  endfunction

  // expected fetch result from the model memory
  function automatic logic [31:0] expected_inst(input logic [31:0] addr);
    logic [31:0] w;
    logic [31:0] nw;
    logic [15:0] lo;
    logic [15:0] hi;
    w  = mem_word(addr);
    nw = mem_word(addr + 32'd4);
    // uncached words come back raw
    if (addr[`ICACHE_UNCACHED_BIT]) begin
      return w;
    end
    lo = addr[1] ? w[31:16] : w[15:0];
    hi = addr[1] ? nw[15:0] : w[31:16];
    // compressed when the opcode bits are not both one
    if (lo[1:0] != 2'b11) begin
      return {16'h0000, lo};
    end
    return {hi, lo};
  endfunction

  // beat decided at the negedge, taken at the next rising edge
  always begin
    @(negedge clk);
    took = !rst && mem_req_valid && mem_rsp.beat_ready;
    if (mem_req_valid && !req_seen) begin
      req_count++;
      last_req = mem_req;
      req_seen = 1'b1;
    end
    @(posedge clk);
    #DRIVE_DELAY;
    if (took) begin
      beat_idx++;
      beat_count++;
    end
    if (!mem_req_valid) begin
      beat_idx = 0;
      req_seen = 1'b0;
    end
    // gaps on about one cycle in four
    mem_rsp.beat_ready = !gaps_on || ($urandom_range(3) != 0);
    mem_rsp.rdata      = mem_word(mem_req.addr + 32'(beat_idx * 4));
  end

  initial begin
    #WATCHDOG_TIME;
    end_with_fail("watchdog expired before the tests finished");
  end

  `include "icache_tests.svh"

  initial begin
    void'($urandom(SEED));
    foreach (mem[i]) begin
      mem[i] = $urandom();
    end
    rst           = 1'b1;
    fetch_valid   = 1'b0;
    fetch_addr    = '0;
    mem_rsp       = '0;
    gaps_on       = 1'b0;
    beat_idx      = 0;
    req_count     = 0;
    beat_count    = 0;
    took          = 1'b0;
    req_seen      = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;
    reset_and_first_miss();
    hit_same_line();
    halfword_alignment();
    uncached_bypass();
    line_eviction();
    random_backpressure();
    $display("RESULT: PASS");
    $finish;
  end

endmodule
